/* hw/mem_pkg.sv */
/*
  Shared bus and cache types for the memory front end.
  Cache geometry is fixed here: 128 direct-mapped lines of one 64-bit word.
*/
`default_nettype none

package mem_pkg;

  // Bus command encoding
  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_cmd_t;

  typedef logic [3:0]  mem_tag_t;   // Zero means not accepted
  typedef logic [63:0] word_t;

  typedef logic [6:0]  line_idx_t;
  typedef logic [53:0] line_tag_t;

  localparam int ICACHE_LINES = 2 ** $bits(line_idx_t);

  // Cache view of an address
  typedef struct packed {
    line_tag_t   tag;
    line_idx_t   index;
    logic [2:0]  offset;   // Byte within the word
  } addr_fields_t;

  typedef union packed {
    logic [63:0]  raw;     // What the bus sees
    addr_fields_t f;
  } addr_t;

  // One bus request
  typedef struct packed {
    bus_cmd_t cmd;
    addr_t    addr;
    word_t    data;
  } mem_req_t;

  // Broadcast from memory when load data returns
  typedef struct packed {
    mem_tag_t tag;
    word_t    data;
  } mem_rsp_t;

  // Request at the data port
  typedef struct packed {
    logic  store;          // 1 = store, 0 = load
    addr_t addr;
    word_t data;
  } data_req_t;

endpackage

`default_nettype wire

/* hw/icache_array.sv */
/*
  Direct-mapped storage, one word per line. Read is combinational.
  Only the valid bits are reset.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_array
  import mem_pkg::*;
(
  input  wire   clock,
  input  wire   rst,
  input  addr_t rd_addr,
  output word_t rd_data,
  output logic  rd_hit,
  input  wire   wr_en,
  input  addr_t wr_addr,
  input  word_t wr_data
);

  logic [ICACHE_LINES-1:0] valid;
  line_tag_t               tag_mem  [ICACHE_LINES];
  word_t                   data_mem [ICACHE_LINES];

  // Lookup
  assign rd_data = data_mem[rd_addr.f.index];
  assign rd_hit  = valid[rd_addr.f.index] && (tag_mem[rd_addr.f.index] == rd_addr.f.tag);

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      valid <= '0;
    end
    else if (wr_en)
    begin
      valid[wr_addr.f.index] <= 1'b1;
    end
  end

  // Tag and data RAMs
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      tag_mem[wr_addr.f.index]  <= wr_addr.f.tag;
      data_mem[wr_addr.f.index] <= wr_data;
    end
  end

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
/*
  Fetch controller. One miss outstanding at a time.
  A fill in flight completes even if fetch_pc moves on.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import mem_pkg::*;
(
  input  wire      clock,
  input  wire      rst,
  input  addr_t    fetch_pc,
  output logic     fetch_valid,
  output word_t    fetch_inst,
  output addr_t    rd_addr,
  input  word_t    rd_data,
  input  wire      rd_hit,
  output logic     wr_en,
  output addr_t    wr_addr,
  output word_t    wr_data,
  output mem_req_t req,
  input  mem_tag_t accept,
  input  mem_rsp_t mem_rsp
);

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REQ,    // Load on the bus until accepted
    IC_WAIT    // Waiting for tagged data
  } ic_state_t;

  ic_state_t state;
  addr_t     miss_addr;   // Line address of the miss
  mem_tag_t  pend_tag;
  logic      fill_now;
  logic      fill_hit;

  ////////////////////
  // Lookup and fill
  ////////////////////

  assign rd_addr  = fetch_pc;
  assign fill_now = (state == IC_WAIT) && (mem_rsp.tag == pend_tag);
  // Returning line is the one being fetched right now
  assign fill_hit = fill_now && (miss_addr.f.tag == fetch_pc.f.tag) &&
                    (miss_addr.f.index == fetch_pc.f.index);

  assign fetch_valid = fill_hit || rd_hit;
  assign fetch_inst  = fill_hit ? mem_rsp.data : rd_data;

  assign wr_en   = fill_now;
  assign wr_addr = miss_addr;
  assign wr_data = mem_rsp.data;

  // Bus request
  assign req.cmd  = (state == IC_REQ) ? BUS_LOAD : BUS_NONE;
  assign req.addr = miss_addr;
  assign req.data = '0;   // Loads carry no data

  ////////////////////
  // Miss FSM
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state <= IC_IDLE;
    end
    else
    begin
      case (state)
        IC_IDLE:
        begin
          if (!rd_hit)
          begin
            state <= IC_REQ;
          end
        end
        IC_REQ:
        begin
          if (accept != '0)
          begin
            state <= IC_WAIT;
          end
        end
        IC_WAIT:
        begin
          if (fill_now)
          begin
            state <= IC_IDLE;
          end
        end
        default: state <= IC_IDLE;
      endcase
    end
  end

  // Miss address and tag, no reset needed
  always_ff @(posedge clock)
  begin
    if (state == IC_IDLE && !rd_hit)
    begin
      miss_addr.raw <= {fetch_pc.f.tag, fetch_pc.f.index, 3'b000};
    end
    if (state == IC_REQ && accept != '0)
    begin
      pend_tag <= accept;
    end
  end

endmodule

`default_nettype wire

/* hw/dport_ctrl.sv */
/*
  Load/store port with a single request outstanding.
  A store is done when accepted; a load when its tagged data returns.
*/
`timescale 1ns/1ps
`default_nettype none

module dport_ctrl
  import mem_pkg::*;
(
  input  wire       clock,
  input  wire       rst,
  input  wire       data_valid,
  input  data_req_t data_req,
  output logic      data_ready,
  output logic      data_done,
  output word_t     data_rdata,
  output mem_req_t  req,
  input  mem_tag_t  accept,
  input  mem_rsp_t  mem_rsp
);

  typedef enum logic [1:0] {
    DP_IDLE,
    DP_REQ,
    DP_WAIT
  } dp_state_t;

  dp_state_t state;
  data_req_t held;        // Request being served
  mem_tag_t  pend_tag;    // Tag of the load in flight
  logic      accepted;
  logic      load_back;

  assign data_ready = (state == DP_IDLE);
  assign accepted   = (state == DP_REQ) && (accept != '0);
  assign load_back  = (state == DP_WAIT) && (mem_rsp.tag == pend_tag);

  assign data_done  = (accepted && held.store) || load_back;
  assign data_rdata = mem_rsp.data;

  assign req.cmd  = (state != DP_REQ) ? BUS_NONE :
                    held.store        ? BUS_STORE : BUS_LOAD;
  assign req.addr = held.addr;
  assign req.data = held.data;

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      state <= DP_IDLE;
    end
    else
    begin
      case (state)
        DP_IDLE:
        begin
          if (data_valid)
          begin
            state <= DP_REQ;
          end
        end
        DP_REQ:
        begin
          if (accepted)
          begin
            state <= held.store ? DP_IDLE : DP_WAIT;
          end
        end
        DP_WAIT:
        begin
          if (load_back)
          begin
            state <= DP_IDLE;
          end
        end
        default: state <= DP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (data_valid && data_ready)
    begin
      held <= data_req;
    end
    if (accepted)
    begin
      pend_tag <= accept;
    end
  end

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
/*
  Combinational bus arbiter. Data side wins whenever it drives a command;
  the accept response goes back only to the client that owned the bus.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import mem_pkg::*;
(
  input  mem_req_t dreq,
  input  mem_req_t ireq,
  output mem_req_t mem_req,
  input  mem_tag_t mem_response,
  output mem_tag_t d_accept,
  output mem_tag_t i_accept
);

  logic d_owns;   // Data port owns the bus this cycle

  assign d_owns = (dreq.cmd != BUS_NONE);

  assign mem_req = d_owns ? dreq : ireq;

  // Route accept tag to the owner
  assign d_accept = d_owns ? mem_response : '0;
  assign i_accept = d_owns ? '0 : mem_response;

endmodule

`default_nettype wire

/* hw/mem_frontend.sv */
/*
  Memory front end: instruction cache and data port on one tagged bus.
  Instruction and data regions must not overlap; stores do not touch the cache.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_frontend
  import mem_pkg::*;
(
  input  wire       clock,
  input  wire       rst,
  input  addr_t     fetch_pc,
  output logic      fetch_valid,
  output word_t     fetch_inst,
  input  wire       data_valid,
  input  data_req_t data_req,
  output logic      data_ready,
  output logic      data_done,
  output word_t     data_rdata,
  output mem_req_t  mem_req,
  input  mem_tag_t  mem_response,
  input  mem_rsp_t  mem_rsp
);

  // Cache array wires
  addr_t    rd_addr;
  word_t    rd_data;
  logic     rd_hit;
  logic     wr_en;
  addr_t    wr_addr;
  word_t    wr_data;

  // Client requests and accepts
  mem_req_t ireq;
  mem_req_t dreq;
  mem_tag_t i_accept;
  mem_tag_t d_accept;

  icache_ctrl u_icache_ctrl (
    .clock       (clock),
    .rst         (rst),
    .fetch_pc    (fetch_pc),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .rd_hit      (rd_hit),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .req         (ireq),
    .accept      (i_accept),
    .mem_rsp     (mem_rsp)
  );

  icache_array u_icache_array (
    .clock   (clock),
    .rst     (rst),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .rd_hit  (rd_hit),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  dport_ctrl u_dport_ctrl (
    .clock      (clock),
    .rst        (rst),
    .data_valid (data_valid),
    .data_req   (data_req),
    .data_ready (data_ready),
    .data_done  (data_done),
    .data_rdata (data_rdata),
    .req        (dreq),
    .accept     (d_accept),
    .mem_rsp    (mem_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .dreq         (dreq),
    .ireq         (ireq),
    .mem_req      (mem_req),
    .mem_response (mem_response),
    .d_accept     (d_accept),
    .i_accept     (i_accept)
  );

endmodule

`default_nettype wire

/* verif/mem_frontend_tb.sv */
/*
  Testbench for the memory front end. Replays verif/mem_vectors.txt against a
  tagged memory model with random accepts and 1 to 4 cycle load latency.
  fetch_pc sits at 0 through reset, so the vectors open with a fetch of 0.
*/
`timescale 1ns/1ps
`default_nettype none

module mem_frontend_tb
  import mem_pkg::*;
();

  localparam int          TIMEOUT   = 200;          // Cycles allowed per wait
  localparam logic [63:0] DATA_BASE = 64'h1_0000;   // Data region starts here

  logic      clock = 1'b0;
  logic      rst = 1'b1;
  addr_t     fetch_pc;
  logic      fetch_valid;
  word_t     fetch_inst;
  logic      data_valid;
  data_req_t data_req;
  logic      data_ready;
  logic      data_done;
  word_t     data_rdata;
  mem_req_t  mem_req;
  mem_tag_t  mem_response = '0;
  mem_rsp_t  mem_rsp = '0;

  mem_frontend u_mem_frontend (
    .clock        (clock),
    .rst          (rst),
    .fetch_pc     (fetch_pc),
    .fetch_valid  (fetch_valid),
    .fetch_inst   (fetch_inst),
    .data_valid   (data_valid),
    .data_req     (data_req),
    .data_ready   (data_ready),
    .data_done    (data_done),
    .data_rdata   (data_rdata),
    .mem_req      (mem_req),
    .mem_response (mem_response),
    .mem_rsp      (mem_rsp)
  );

  always #4 clock = ~clock;

  ////////////////////
  // Memory model
  ////////////////////

  typedef struct packed {
    mem_tag_t    tag;
    word_t       data;
    logic [31:0] due;   // Cycle the data goes out
  } ret_t;

  integer      seed = 32'h439e_07b1;
  word_t       mem_data [logic [63:0]];
  int          load_cnt [logic [63:0]];   // Accepted loads per address
  ret_t        ret_q [$];
  mem_tag_t    next_tag = 4'd1;
  logic [31:0] cyc = '0;
  int          bus_cmds = 0;
  logic [31:0] draw_acc;
  logic [31:0] draw_lat;
  ret_t        ret_new;
  mem_rsp_t    rsp_next;
  logic        sent;
  mem_req_t    dreq_exp = '0;   // Last request taken by the data port

  function automatic word_t mem_read(input logic [63:0] a);
    if (mem_data.exists(a))
    begin
      return mem_data[a];
    end
    return ~a;   // Unwritten words
  endfunction

  function automatic int loads_at(input logic [63:0] a);
    if (load_cnt.exists(a))
    begin
      return load_cnt[a];
    end
    return 0;
  endfunction

  // Whole command from the data port, or a plain line load from fetch
  function automatic logic one_client(input mem_req_t q);
    if (q == dreq_exp)
    begin
      return 1'b1;
    end
    return (q.cmd == BUS_LOAD) && (q.data == '0) && (q.addr.raw[2:0] == 3'd0) &&
           (q.addr.raw < DATA_BASE);
  endfunction

  always @(negedge clock)
  begin
    if (!rst && mem_req.cmd != BUS_NONE)
    begin
      check("bus carries one client", {63'd0, one_client(mem_req)}, 64'd1);
    end
  end

  // Accepts are taken mid-cycle, where command and response are settled
  always @(negedge clock)
  begin
    if (!rst && mem_req.cmd != BUS_NONE && mem_response != '0)
    begin
      bus_cmds = bus_cmds + 1;
      if (mem_req.cmd == BUS_STORE)
      begin
        mem_data[mem_req.addr.raw] = mem_req.data;
      end
      else
      begin
        load_cnt[mem_req.addr.raw] = loads_at(mem_req.addr.raw) + 1;
        draw_lat = $random(seed);
        ret_new.tag  = mem_response;
        ret_new.data = mem_read(mem_req.addr.raw);
        ret_new.due  = cyc + 32'd1 + {30'd0, draw_lat[1:0]};
        ret_q.push_back(ret_new);
      end
      next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    end
  end

  always @(posedge clock)
  begin
    cyc = cyc + 32'd1;
    mem_rsp <= '0;
    sent = 1'b0;
    for (int k = 0; k < ret_q.size(); k++)
    begin
      if (!sent && ret_q[k].due <= cyc)   // One return per cycle, late ones slip
      begin
        rsp_next.tag  = ret_q[k].tag;
        rsp_next.data = ret_q[k].data;
        mem_rsp <= rsp_next;
        ret_q.delete(k);
        sent = 1'b1;
      end
    end
    draw_acc = $random(seed);
    if (rst)
    begin
      mem_response <= '0;
    end
    else
    begin
      mem_response <= draw_acc[0] ? next_tag : '0;   // Accept about half
    end
  end

  ////////////////////
  // Checks and waits
  ////////////////////

  int   errors = 0;
  logic stalled = 1'b0;

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic report_stall(input string what, input logic [63:0] a);
    $display("timeout: %s at %h did not finish within %0d cycles", what, a, TIMEOUT);
    errors = errors + 1;
    stalled = 1'b1;
  endtask

  task automatic wait_fetch(input logic [63:0] a, input logic [63:0] exp, input logic hit);
    logic got;
    int   n;
    got = 1'b0;
    n = 0;
    while (!got && n < TIMEOUT)
    begin
      @(negedge clock);
      got = fetch_valid;
      if (hit && n == 0)
      begin
        check("fetch hit in first cycle", {63'd0, fetch_valid}, 64'd1);
        check("bus idle on hit", {62'd0, mem_req.cmd}, {62'd0, BUS_NONE});
      end
      n = n + 1;
    end
    if (!got)
    begin
      report_stall("fetch", a);
    end
    else
    begin
      check("fetch word", fetch_inst, exp);
    end
  endtask

  // Called on a rising edge; d is store data or the expected load word
  task automatic data_op(input logic st, input logic [63:0] a, input logic [63:0] d);
    data_req_t r;
    logic      got;
    int        n;
    r.store    = st;
    r.addr.raw = a;
    r.data     = st ? d : '0;
    data_valid <= 1'b1;
    data_req   <= r;
    got = 1'b0;
    n = 0;
    while (!got && n < TIMEOUT)
    begin
      @(negedge clock);
      got = data_ready;
      n = n + 1;
    end
    if (!got)
    begin
      report_stall("data request", a);
    end
    else
    begin
      @(posedge clock);   // Request taken here
      data_valid <= 1'b0;
      dreq_exp.cmd  = st ? BUS_STORE : BUS_LOAD;
      dreq_exp.addr = r.addr;
      dreq_exp.data = r.data;
      got = 1'b0;
      n = 0;
      while (!got && n < TIMEOUT)
      begin
        @(negedge clock);
        got = data_done;
        n = n + 1;
      end
      if (!got)
      begin
        report_stall(st ? "store" : "load", a);
      end
      else if (!st)
      begin
        check("load data", data_rdata, d);
      end
    end
  endtask

  ////////////////////
  // Vector replay
  ////////////////////

  logic [63:0] vec [0:191];
  logic        cache_vld [ICACHE_LINES];   // Expected cache contents
  line_tag_t   cache_tag [ICACHE_LINES];

  initial
  begin : main
    logic [63:0] op;
    logic [63:0] a;
    logic [63:0] d;
    addr_t       pa;
    logic        hit;
    int          i;
    int          num;
    int          failed;
    int          errs0;
    int          cmds0;
    int          loads0;
    int          exp_cmds;
    string       name;
    fetch_pc   = '0;
    data_valid = 1'b0;
    data_req   = '0;
    for (i = 0; i < ICACHE_LINES; i++)
    begin
      cache_vld[i] = 1'b0;
    end
    $readmemh("verif/mem_vectors.txt", vec);

    repeat (5) @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    check("reset bus command", {62'd0, mem_req.cmd}, {62'd0, BUS_NONE});
    check("reset fetch_valid", {63'd0, fetch_valid}, 64'd0);
    check("reset data_done", {63'd0, data_done}, 64'd0);
    check("reset data_ready", {63'd0, data_ready}, 64'd1);
    $display("test 0 reset: %s", (errors == 0) ? "ok" : "error");
    failed = (errors == 0) ? 0 : 1;
    num = 1;

    i = 0;
    while (i < 63 && vec[3*i] != 64'hff && !stalled)
    begin
      op = vec[3*i];
      a  = vec[3*i+1];
      d  = vec[3*i+2];
      pa.raw = a;
      hit = cache_vld[pa.f.index] && (cache_tag[pa.f.index] == pa.f.tag);
      @(posedge clock);
      errs0  = errors;
      cmds0  = bus_cmds;
      loads0 = loads_at(a);
      case (op)
        64'd1:
        begin
          name = "fetch";
          fetch_pc.raw <= a;
          wait_fetch(a, d, hit);
          exp_cmds = hit ? 0 : 1;
        end
        64'd2, 64'd3:
        begin
          name = (op == 64'd2) ? "store" : "load";
          data_op(op == 64'd2, a, d);
          exp_cmds = 1;
        end
        default:
        begin
          // Data op from the next line runs while this fetch misses
          name = "fetch with data op";
          fetch_pc.raw <= a;
          data_op(vec[3*i+3] == 64'd2, vec[3*i+4], vec[3*i+5]);
          if (!stalled)
          begin
            wait_fetch(a, d, 1'b0);
          end
          exp_cmds = 2;
          i = i + 1;
        end
      endcase
      @(posedge clock);
      if (!stalled)
      begin
        check("accepted bus commands", 64'(bus_cmds - cmds0), 64'(exp_cmds));
        if ((op == 64'd1 && !hit) || op == 64'd4)
        begin
          check("line loads", 64'(loads_at(a) - loads0), 64'd1);
        end
      end
      if (op == 64'd1 || op == 64'd4)
      begin
        cache_vld[pa.f.index] = 1'b1;
        cache_tag[pa.f.index] = pa.f.tag;
      end
      $display("test %0d %s at %h: %s", num, name, a, (errors == errs0) ? "ok" : "error");
      if (errors != errs0)
      begin
        failed = failed + 1;
      end
      num = num + 1;
      i = i + 1;
    end

    $display("%0d tests, %0d failed, %0d errors", num, failed, errors);
    if (errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/mem_vectors.txt */
// op addr data: op 1 fetch, 2 store, 3 load; data is store data or expected word
// op 4 fetches while the data op on the next line runs; ff ends the list
1 0000000000000000 ffffffffffffffff
1 0000000000000040 ffffffffffffffbf
1 0000000000000040 ffffffffffffffbf
1 0000000000000000 ffffffffffffffff
1 0000000000000440 fffffffffffffbbf
1 0000000000000040 ffffffffffffffbf
2 0000000000010000 0123456789abcdef
3 0000000000010000 0123456789abcdef
3 0000000000010008 fffffffffffefff7
4 0000000000000880 fffffffffffff77f
3 0000000000010000 0123456789abcdef
2 0000000000010010 deadbeefcafef00d
4 0000000000000c80 fffffffffffff37f
2 0000000000010018 55aa55aa00ff00ff
3 0000000000010018 55aa55aa00ff00ff
3 0000000000010010 deadbeefcafef00d
1 0000000000000880 fffffffffffff77f
ff 0 0

/* list.f */
hw/mem_pkg.sv
hw/icache_array.sv
hw/icache_ctrl.sv
hw/dport_ctrl.sv
hw/mem_arbiter.sv
hw/mem_frontend.sv
verif/mem_frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory front end testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module mem_frontend_tb -o mem_frontend_sim
./obj_dir/mem_frontend_sim | tee sim.log

if grep -qx "TEST PASS" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
